// ==== Makefile ====
# Verilator build and run of the accumulator testbench
SIM = obj_dir/VaccumTb
SOURCES = fp16Accum.f $(wildcard design/*.sv) $(wildcard testbench/*.sv testbench/*.svh)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "test passed" sim.log

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f fp16Accum.f --top-module accumTb

clean:
	rm -rf obj_dir sim.log

// ==== design/accumCtrl.sv ====
`timescale 1ns/100ps

module accumCtrl (
	input logic ap_clk,
	input logic ap_rst,
	input logic ap_start,
	input logic ap_continue,
	input fp16Pkg::fp16T memQ,
	input fp16Pkg::fp16T sumOut,
	output logic ap_done,
	output logic ap_idle,
	output logic ap_ready,
	output fp16Pkg::memAddrT memAddr,
	output logic memCe,
	output fp16Pkg::fp16T opA,
	output fp16Pkg::fp16T opB,
	output fp16Pkg::fp16T accumSum,
	output logic accumSumValid
);
	import fp16Pkg::*;

	ctrlStateT state;
	countT count;        // Elements already added
	logic [1:0] waitCnt; // Adder wait
	fp16T sumReg;        // Running sum and adder operand A
	fp16T opReg;         // Captured memory word
	fp16T lastSum;       // Holds the published result
	logic doneHeld;
	logic startAccept;
	logic finishing;

	assign startAccept = (state == idle) && ap_start && !doneHeld;
	assign finishing = (state == fetch) && (count == countT'(numElems));

	assign memCe = (state == fetch) && !finishing;
	assign memAddr = count[2:0];
	assign opA = sumReg;
	assign opB = opReg;

	// Single cycle strobes
	assign accumSumValid = finishing;
	assign ap_ready = finishing;
	assign ap_done = finishing | doneHeld;
	assign ap_idle = (state == idle) && !ap_start;
	assign accumSum = finishing ? sumReg : lastSum;

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= idle;
			count <= '0;
			waitCnt <= '0;
			doneHeld <= 1'b0;
			sumReg <= '0;
			opReg <= '0;
			lastSum <= '0;
		end else begin
			if (ap_continue) begin
				doneHeld <= 1'b0; // Continue wins over a new done
			end else if (finishing) begin
				doneHeld <= 1'b1;
			end
			case (state)
				idle: begin
					if (startAccept) begin
						sumReg <= '0; // Start from +0
						count <= '0;
						state <= fetch;
					end
				end
				fetch: begin
					if (finishing) begin
						lastSum <= sumReg;
						state <= idle;
					end else begin
						state <= load; // Read issued this cycle
					end
				end
				load: begin
					opReg <= memQ; // Memory word valid now
					waitCnt <= '0;
					state <= addWait;
				end
				addWait: begin
					if (waitCnt == 2'(addLatency - 1)) begin
						sumReg <= sumOut;
						count <= count + countT'(1);
						state <= fetch;
					end else begin
						waitCnt <= waitCnt + 2'd1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Reads only while elements remain
	memReadInRange: assert property (@(posedge ap_clk) disable iff (ap_rst)
		memCe |-> (count < countT'(numElems)));

	// Result and ready strobes last one cycle
	validSingleCycle: assert property (@(posedge ap_clk) disable iff (ap_rst)
		accumSumValid |=> !accumSumValid && !ap_ready);

	// Done only ever rises together with the result strobe
	doneRiseWithValid: assert property (@(posedge ap_clk) disable iff (ap_rst)
		$rose(ap_done) |-> accumSumValid);

endmodule

// ==== design/fp16Accum.sv ====
`timescale 1ns/100ps

module fp16Accum (
	input logic ap_clk,
	input logic ap_rst,
	input logic ap_start,
	input logic ap_continue,
	input fp16Pkg::fp16T memQ,
	output logic ap_done,
	output logic ap_idle,
	output logic ap_ready,
	output fp16Pkg::memAddrT memAddr,
	output logic memCe,
	output fp16Pkg::fp16T accumSum,
	output logic accumSumValid
);
	import fp16Pkg::*;

	fp16T opA;    // Running sum
	fp16T opB;    // Current element
	fp16T sumOut;

	accumCtrl ctrl (
		.ap_clk        (ap_clk),
		.ap_rst        (ap_rst),
		.ap_start      (ap_start),
		.ap_continue   (ap_continue),
		.memQ          (memQ),
		.sumOut        (sumOut),
		.ap_done       (ap_done),
		.ap_idle       (ap_idle),
		.ap_ready      (ap_ready),
		.memAddr       (memAddr),
		.memCe         (memCe),
		.opA           (opA),
		.opB           (opB),
		.accumSum      (accumSum),
		.accumSumValid (accumSumValid)
	);

	fp16Adder adder (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.opA    (opA),
		.opB    (opB),
		.sumOut (sumOut)
	);

endmodule

// ==== design/fp16Adder.sv ====
`timescale 1ns/100ps

module fp16Adder (
	input logic ap_clk,
	input logic ap_rst,
	input fp16Pkg::fp16T opA,
	input fp16Pkg::fp16T opB,
	output fp16Pkg::fp16T sumOut
);
	import fp16Pkg::*;

	alignStageT alignComb;
	alignStageT alignReg;
	normStageT normComb;
	normStageT normReg;

	// Stage one, classify and order by magnitude
	fp16Unpack unpack (
		.opA      (opA),
		.opB      (opB),
		.alignOut (alignComb)
	);

	// Stage two, shift and add
	fp16AlignAdd alignAdd (
		.alignIn (alignReg),
		.normOut (normComb)
	);

	// Stage three, normalize and round straight onto sumOut
	fp16NormRound normRound (
		.normIn (normReg),
		.result (sumOut)
	);

	// New pair every cycle, operand registers upstream form the first slot
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			alignReg <= '0; // All zero content decodes as +0
			normReg <= '0;
		end else begin
			alignReg <= alignComb;
			normReg <= normComb;
		end
	end

	// Pipeline flushed to known values once reset has been released
	sumKnownAfterReset: assert property (
		@(posedge ap_clk) $fell(ap_rst) |-> ##3 !$isunknown(sumOut)
	);

endmodule

// ==== design/fp16AlignAdd.sv ====
`timescale 1ns/100ps

module fp16AlignAdd (
	input fp16Pkg::alignStageT alignIn,
	output fp16Pkg::normStageT normOut
);
	import fp16Pkg::*;

	sigT shifted;
	sigT lostMask;
	sigT aligned;
	logic sticky;

	always_comb begin
		// Right shift, anything past the sticky slot is OR'ed back in
		shifted = alignIn.sigSmall >> alignIn.alignDist;
		lostMask = ~(sigT'('1) << alignIn.alignDist); // All ones once dist >= 14
		sticky = |(alignIn.sigSmall & lostMask);
		aligned = {shifted[mantWidth+3:1], shifted[0] | sticky};
	end

	always_comb begin
		normOut.sign = alignIn.sign;
		normOut.expLarge = alignIn.expLarge;
		normOut.special = alignIn.special;
		// Zero plus zero keeps the sign only when both agree
		normOut.zeroSign = alignIn.sign & ~alignIn.effSub;
		if (alignIn.effSub) begin
			normOut.sum = {1'b0, alignIn.sigLarge} - {1'b0, aligned}; // Larger on top, no borrow
		end else begin
			normOut.sum = {1'b0, alignIn.sigLarge} + {1'b0, aligned};
		end
	end

endmodule

// ==== design/fp16NormRound.sv ====
`timescale 1ns/100ps

module fp16NormRound (
	input fp16Pkg::normStageT normIn,
	output fp16Pkg::fp16T result
);
	import fp16Pkg::*;

	logic [3:0] lzCount;
	sigT normSig;
	logic signed [6:0] normExp;
	logic signed [6:0] roundExp;
	logic [mantWidth:0] mantRnd;
	logic guardBit;
	logic roundBit;
	logic stickyBit;
	logic roundUp;

	// Leading zeros below the carry bit, highest set bit wins
	always_comb begin
		lzCount = 4'd0;
		for (int i = 0; i < mantWidth + 4; i++) begin
			if (normIn.sum[i]) begin
				lzCount = 4'(mantWidth + 3 - i);
			end
		end
	end

	always_comb begin
		if (normIn.sum[mantWidth+4]) begin
			// Carry out, one step right and keep the dropped bit in sticky
			normSig = {normIn.sum[mantWidth+4:2], normIn.sum[1] | normIn.sum[0]};
			normExp = $signed({2'b00, normIn.expLarge}) + 7'sd1;
		end else begin
			// Big left shifts only follow close cancels, low bits are exact then
			normSig = normIn.sum[mantWidth+3:0] << lzCount;
			normExp = $signed({2'b00, normIn.expLarge}) - $signed({3'b000, lzCount});
		end
	end

	assign guardBit = normSig[2];
	assign roundBit = normSig[1];
	assign stickyBit = normSig[0];
	assign roundUp = guardBit & (roundBit | stickyBit | normSig[3]); // Nearest, ties to even

	assign mantRnd = {1'b0, normSig[mantWidth+2:3]} + {{mantWidth{1'b0}}, roundUp};
	// Fraction wraps to zero on carry, exponent picks it up
	assign roundExp = normExp + $signed({6'b000000, mantRnd[mantWidth]});

	always_comb begin
		if (normIn.special.isNan) begin
			result = canonicalNan;
		end else if (normIn.special.isInf) begin
			result = {normIn.special.infSign, expT'(expMax), mantT'(0)};
		end else if (normIn.sum == '0) begin
			// Exact cancel is +0
			result = {normIn.special.bothZero ? normIn.zeroSign : 1'b0, expT'(0), mantT'(0)};
		end else if (roundExp < 7'sd1) begin
			result = {normIn.sign, expT'(0), mantT'(0)}; // Flush tiny result
		end else if (roundExp >= expMax) begin
			result = {normIn.sign, expT'(expMax), mantT'(0)}; // Overflow
		end else begin
			result = {normIn.sign, roundExp[expWidth-1:0], mantRnd[mantWidth-1:0]};
		end
	end

endmodule

// ==== design/fp16Pkg.sv ====
package fp16Pkg;

	localparam int expWidth = 5;   // Biased exponent field
	localparam int mantWidth = 10; // Stored fraction, hidden one not included
	localparam int expBias = 15;
	localparam int expMax = 31;    // All ones, reserved for Inf and NaN
	localparam int numElems = 8;   // Words summed per run
	localparam int addLatency = 3; // Edges from operand register to sum capture

	typedef logic [expWidth+mantWidth:0] fp16T;
	typedef logic [expWidth-1:0] expT;
	typedef logic [mantWidth-1:0] mantT;
	typedef logic [mantWidth+3:0] sigT;   // Hidden one, fraction, guard, round, sticky
	typedef logic [mantWidth+4:0] sumT;   // sigT plus carry out
	typedef logic [2:0] memAddrT;
	typedef logic [3:0] countT;           // Needs to reach numElems

	// Quiet NaN, positive, top fraction bit only
	localparam fp16T canonicalNan = 16'h7E00;

	typedef struct packed {
		logic isNan;    // NaN operand or Inf minus Inf
		logic isInf;    // Some infinity survives
		logic infSign;
		logic bothZero; // Both operands zero after flush
	} specialT;

	// Unpack to align/add
	typedef struct packed {
		logic sign;     // Sign of larger magnitude
		logic effSub;   // Operand signs differ
		expT expLarge;
		sigT sigLarge;
		sigT sigSmall;  // Not yet shifted
		logic [4:0] alignDist;
		specialT special;
	} alignStageT;

	// Align/add to normalize/round
	typedef struct packed {
		logic sign;
		expT expLarge;
		sumT sum;
		specialT special;
		logic zeroSign; // Sign for zero plus zero
	} normStageT;

	typedef enum logic [1:0] {idle, fetch, load, addWait} ctrlStateT;

endpackage

// ==== design/fp16Unpack.sv ====
`timescale 1ns/100ps

module fp16Unpack (
	input fp16Pkg::fp16T opA,
	input fp16Pkg::fp16T opB,
	output fp16Pkg::alignStageT alignOut
);
	import fp16Pkg::*;

	expT expA;
	expT expB;
	mantT mantA;
	mantT mantB;
	logic signA;
	logic signB;
	logic zeroA;
	logic zeroB;
	logic infA;
	logic infB;
	logic nanA;
	logic nanB;
	logic swap;
	logic [expWidth+mantWidth-1:0] magA;
	logic [expWidth+mantWidth-1:0] magB;
	sigT sigA;
	sigT sigB;

	assign signA = opA[expWidth+mantWidth];
	assign signB = opB[expWidth+mantWidth];
	assign expA = opA[mantWidth +: expWidth];
	assign expB = opB[mantWidth +: expWidth];
	assign mantA = opA[mantWidth-1:0];
	assign mantB = opB[mantWidth-1:0];

	// Exponent zero covers subnormals too, they count as zero
	assign zeroA = (expA == '0);
	assign zeroB = (expB == '0);
	assign infA = (expA == expT'(expMax)) && (mantA == '0);
	assign infB = (expB == expT'(expMax)) && (mantB == '0);
	assign nanA = (expA == expT'(expMax)) && (mantA != '0);
	assign nanB = (expB == expT'(expMax)) && (mantB != '0);

	// Flushed magnitudes compare as plain integers
	assign magA = zeroA ? '0 : opA[expWidth+mantWidth-1:0];
	assign magB = zeroB ? '0 : opB[expWidth+mantWidth-1:0];
	assign swap = (magB > magA); // Ties keep A on top

	assign sigA = zeroA ? '0 : {1'b1, mantA, 3'b000};
	assign sigB = zeroB ? '0 : {1'b1, mantB, 3'b000};

	always_comb begin
		alignOut.sign = swap ? signB : signA;
		alignOut.effSub = signA ^ signB;
		alignOut.expLarge = swap ? expB : expA;
		alignOut.sigLarge = swap ? sigB : sigA;
		alignOut.sigSmall = swap ? sigA : sigB;
		alignOut.alignDist = swap ? (expB - expA) : (expA - expB); // Never negative
		alignOut.special.isNan = nanA | nanB | (infA & infB & (signA ^ signB));
		alignOut.special.isInf = infA | infB;
		alignOut.special.infSign = infA ? signA : signB;
		alignOut.special.bothZero = zeroA & zeroB;
	end

endmodule

// ==== fp16Accum.f ====
+incdir+testbench
design/fp16Pkg.sv
design/fp16Unpack.sv
design/fp16AlignAdd.sv
design/fp16NormRound.sv
design/fp16Adder.sv
design/accumCtrl.sv
design/fp16Accum.sv
testbench/accumTb.sv

// ==== testbench/accumRef.svh ====
// Half-precision add on exact integers, rounded once at the end
// Finite values are integers on the 2^-24 grid
function automatic fp16T fp16AddRef(input fp16T a, input fp16T b);
	logic signA;
	logic signB;
	logic sign;
	int expA;
	int expB;
	int msb;
	int shift;
	int biased;
	logic nanA;
	logic nanB;
	logic infA;
	logic infB;
	longint valA;
	longint valB;
	longint total;
	longint mag;
	longint sig;
	longint rem;
	longint half;
	signA = a[15];
	signB = b[15];
	expA = a[14:10];
	expB = b[14:10];
	nanA = (expA == 31) && (a[9:0] != 0);
	nanB = (expB == 31) && (b[9:0] != 0);
	infA = (expA == 31) && (a[9:0] == 0);
	infB = (expB == 31) && (b[9:0] == 0);
	if (nanA || nanB || (infA && infB && (signA != signB)))
		return 16'h7E00; // Quiet NaN, positive
	if (infA)
		return {signA, 5'h1F, 10'h000};
	if (infB)
		return {signB, 5'h1F, 10'h000};
	// Exponent zero counts as zero, subnormals included
	valA = (expA == 0) ? 0 : longint'(1024 + a[9:0]) << (expA - 1);
	valB = (expB == 0) ? 0 : longint'(1024 + b[9:0]) << (expB - 1);
	if (signA)
		valA = -valA;
	if (signB)
		valB = -valB;
	if ((valA == 0) && (valB == 0))
		return {signA & signB, 15'h0000}; // Zero sum keeps a common sign only
	total = valA + valB;
	if (total == 0)
		return 16'h0000; // Exact cancel
	sign = (total < 0);
	mag = sign ? -total : total;
	msb = 0;
	for (int i = 0; i < 48; i++) begin
		if (mag[i])
			msb = i;
	end
	if (msb > 10) begin
		shift = msb - 10;
		sig = mag >> shift;
		rem = mag & ((64'sd1 << shift) - 1);
		half = 64'sd1 << (shift - 1);
		if ((rem > half) || ((rem == half) && sig[0]))
			sig = sig + 1; // Nearest, ties to even
	end else begin
		sig = mag << (10 - msb);
	end
	biased = msb - 9; // Leading one at bit 10 is exponent 1
	if (sig == 2048) begin
		sig = 1024;
		biased = biased + 1;
	end
	if (biased < 1)
		return {sign, 15'h0000}; // Flush
	if (biased >= 31)
		return {sign, 5'h1F, 10'h000}; // Overflow
	return {sign, 5'(biased), sig[9:0]};
endfunction

// Folds the words from +0 in address order
function automatic fp16T accumRef(input fp16T words [numElems]);
	fp16T acc;
	acc = 16'h0000;
	for (int i = 0; i < numElems; i++) begin
		acc = fp16AddRef(acc, words[i]);
	end
	return acc;
endfunction

// ==== testbench/accumTb.sv ====
`timescale 1ns/100ps

module accumTb;
	import fp16Pkg::*;

	`include "accumRef.svh"

	localparam int startTimeout = 10;
	localparam int runTimeout = 100;  // Run needs 41 cycles

	logic ap_clk;
	logic ap_rst;
	logic ap_start;
	logic ap_continue;
	fp16T memQ;
	logic ap_done;
	logic ap_idle;
	logic ap_ready;
	memAddrT memAddr;
	logic memCe;
	fp16T accumSum;
	logic accumSumValid;

	fp16T mem [numElems];  // Word store behind the read port
	memAddrT rdAddr;
	memAddrT readLog[$];   // Addresses in read order
	fp16T expectedSum;
	int validCount;
	int cycleCount = 0;

	fp16Accum dut (
		.ap_clk        (ap_clk),
		.ap_rst        (ap_rst),
		.ap_start      (ap_start),
		.ap_continue   (ap_continue),
		.memQ          (memQ),
		.ap_done       (ap_done),
		.ap_idle       (ap_idle),
		.ap_ready      (ap_ready),
		.memAddr       (memAddr),
		.memCe         (memCe),
		.accumSum      (accumSum),
		.accumSumValid (accumSumValid)
	);

	initial begin
		ap_clk = 1'b0;
		forever #10 ap_clk = ~ap_clk;
	end

	always @(posedge ap_clk) cycleCount++; // Edge index

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("test failed");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timed out at %0t waiting for %s", $time, what);
		$display("test failed");
		$fatal(1, "timeout");
	endtask

	// One cycle read latency with the request seen mid cycle
	initial begin
		memQ = '0;
		forever begin
			@(negedge ap_clk);
			if (memCe) begin
				rdAddr = memAddr;
				readLog.push_back(memAddr);
				@(posedge ap_clk);
				#2 memQ = mem[rdAddr];
			end
		end
	end

	// Result compare
	always @(negedge ap_clk) begin
		if (!ap_rst && accumSumValid) begin
			checkValue(accumSum, expectedSum, "accumSum");
			checkValue(ap_ready, 1, "ap_ready with accumSumValid");
			validCount++;
		end
	end

	// Normal values of mixed sign that keep every sum finite
	task automatic loadRandom();
		for (int i = 0; i < numElems; i++) begin
			mem[i] = {1'($urandom_range(0, 1)), 5'($urandom_range(3, 26)), 10'($urandom)};
		end
	endtask

	task automatic runAccum(input fp16T expected, input logic startWhileHeld);
		int waitCnt;
		int acceptCycle;
		expectedSum = expected;
		validCount = 0;
		readLog.delete();
		@(posedge ap_clk);
		#2 ap_start = 1'b1;
		acceptCycle = cycleCount + 1; // Next edge samples the start
		waitCnt = 0;
		@(negedge ap_clk);
		while (!memCe && waitCnt < startTimeout) begin
			@(negedge ap_clk);
			waitCnt++;
		end
		if (!memCe)
			reportTimeout("the first memory read after ap_start");
		@(posedge ap_clk);
		#2 ap_start = 1'b0;
		waitCnt = 0;
		@(negedge ap_clk);
		while (!ap_done && waitCnt < runTimeout) begin
			checkValue(ap_idle, 0, "ap_idle while busy");
			@(negedge ap_clk);
			waitCnt++;
		end
		if (!ap_done)
			reportTimeout("ap_done");
		checkValue(cycleCount - acceptCycle + 1, numElems * (2 + addLatency) + 1,
			"cycles from accepting edge to ap_done");
		// Start must not launch reads while done is held
		for (int i = 0; i < 4; i++) begin
			@(posedge ap_clk);
			#2 ap_start = startWhileHeld;
			@(negedge ap_clk);
			checkValue(ap_done, 1, "ap_done while held");
			checkValue(memCe, 0, "memCe while done held");
			checkValue(accumSumValid, 0, "accumSumValid after the pulse");
			checkValue(ap_idle, !startWhileHeld, "ap_idle while done held");
		end
		@(posedge ap_clk);
		#2;
		ap_start = 1'b0;
		ap_continue = 1'b1;
		@(posedge ap_clk);
		#2 ap_continue = 1'b0;
		@(negedge ap_clk);
		checkValue(ap_done, 0, "ap_done after ap_continue");
		checkValue(ap_idle, 1, "ap_idle after the run");
		checkValue(accumSum, expected, "accumSum held after the run");
		checkValue(validCount, 1, "accumSumValid pulses per run");
		checkValue(readLog.size(), numElems, "memory reads per run");
		for (int i = 0; i < readLog.size(); i++) begin
			checkValue(readLog[i], i, "read address order");
		end
	endtask

	initial begin
		void'($urandom(98360));
		ap_rst = 1'b1;
		ap_start = 1'b0;
		ap_continue = 1'b0;
		repeat (4) @(posedge ap_clk);
		#2 ap_rst = 1'b0;
		@(negedge ap_clk);
		checkValue(memCe, 0, "memCe after reset");
		checkValue(ap_done, 0, "ap_done after reset");
		checkValue(ap_ready, 0, "ap_ready after reset");
		checkValue(accumSumValid, 0, "accumSumValid after reset");
		checkValue(ap_idle, 1, "ap_idle after reset");
		checkValue(accumSum, 16'h0000, "accumSum after reset");
		for (int r = 0; r < 20; r++) begin
			loadRandom();
			runAccum(accumRef(mem), (r % 5) == 0);
		end
		// Cancelling pairs and negative zeros
		mem = '{16'h3C00, 16'hBC00, 16'h4500, 16'hC500, 16'h2E66, 16'hAE66, 16'h7BFF, 16'hFBFF};
		runAccum(16'h0000, 1'b0);
		mem = '{default: 16'h8000};
		runAccum(16'h0000, 1'b1);
		// Halfway cases that round down to even and then up to even
		mem = '{16'h3C00, 16'h1000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
		runAccum(16'h3C00, 1'b0);
		mem = '{16'h3C01, 16'h1000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
		runAccum(16'h3C02, 1'b0);
		mem = '{default: 16'h7BFF};
		runAccum(16'h7C00, 1'b0); // Overflow
		mem = '{default: 16'hFBFF};
		runAccum(16'hFC00, 1'b0);
		mem = '{16'h7C00, 16'hFC00, 16'h3C00, 16'h3C00, 16'h3C00, 16'h3C00, 16'h3C00, 16'h3C00};
		runAccum(canonicalNan, 1'b0);
		mem = '{16'h3C00, 16'h3C00, 16'h3C00, 16'h3C00, 16'h3C00, 16'hFE55, 16'h3C00, 16'h3C00};
		runAccum(canonicalNan, 1'b0);
		mem = '{16'h3C00, 16'h4000, 16'hFC00, 16'h7BFF, 16'h3C00, 16'h3C00, 16'h3C00, 16'h3C00};
		runAccum(16'hFC00, 1'b0); // Lone infinity survives
		// Subnormals add nothing and a tiny difference flushes with its sign
		mem = '{16'h03FF, 16'h0400, 16'h0001, 16'h83FF, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
		runAccum(16'h0400, 1'b0);
		mem = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h8401, 16'h0400};
		runAccum(16'h8000, 1'b1);
		$display("test passed");
		$finish;
	end

endmodule
